// ==== design/memPkg.sv ====
`default_nettype none

package memPkg;

    // Word and line geometry
    localparam int wordBits     = 32;
    localparam int lineBits     = 512;
    localparam int wordsPerLine = lineBits / wordBits;

    // Address split for the direct-mapped cache
    localparam int offsetLsb  = 2;
    localparam int offsetMsb  = 5;
    localparam int indexLsb   = 6;
    localparam int indexMsb   = 9;
    localparam int cacheLines = 16;
    localparam int tagLsb     = 10;

    // Main memory holds 4 KB and aliases above that
    localparam int memBlocks = 64;

    // Block memory answer latencies in cycles
    localparam int fillLatency  = 4;
    localparam int evictLatency = 3;
    // Counter sized for the longer of the two latencies
    localparam int latCountBits = $clog2(fillLatency + 1);

    // Region nibbles after reset
    localparam logic [3:0] dataRegionReset = 4'h1;
    localparam logic [3:0] fftRegionReset  = 4'h2;

    // One cache line viewed as words
    typedef struct packed {
        logic [wordsPerLine-1:0][wordBits-1:0] words;
    } line_t;

    // Load or store from the pipeline
    typedef struct packed {
        logic                read;
        logic                write;
        logic [wordBits-1:0] addr;
        logic [wordBits-1:0] wdata;
    } memReq_t;

    // Access exceptions raised by the guard
    typedef struct packed {
        logic accessEx;
        logic readEx;
        logic fftEx;
    } memExc_t;

    // Region register write where sel 0 is data and sel 1 is FFT
    typedef struct packed {
        logic       en;
        logic       sel;
        logic [3:0] value;
    } cfgWrite_t;

    // Stage to block memory
    typedef struct packed {
        logic                         miss;
        logic                         evict;
        logic [wordBits-indexLsb-1:0] lineAddr;
        line_t                        evictLine;
    } mcReq_t;

    // Block memory back to the stage
    typedef struct packed {
        logic  dataValid;
        logic  evictDone;
        line_t fillLine;
    } mcResp_t;

endpackage

`default_nettype wire

// ==== design/dataCache.sv ====
`default_nettype none

module dataCache (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          en,
    input  wire logic          rd,
    input  wire logic          wr,
    input  wire logic          ld,
    input  wire logic [31:0]   addr,
    input  wire logic [31:0]   wdata,
    input  wire memPkg::line_t blkIn,
    output logic [31:0]        rdata,
    output logic               hit,
    output logic               miss,
    output logic               evictNeeded,
    output memPkg::line_t      blkOut,
    output logic [31:0]        victimAddr
);

    import memPkg::*;

    localparam int tagBits   = wordBits - tagLsb;
    localparam int indexBits = indexMsb - indexLsb + 1;

    // Line storage and tags
    line_t              dataArr [cacheLines];
    logic [tagBits-1:0] tagArr  [cacheLines];

    // Per-line state bits
    logic [cacheLines-1:0] validArr;
    logic [cacheLines-1:0] dirtyArr;

    // Fields of the incoming address
    logic [tagBits-1:0]           addrTag;
    logic [indexBits-1:0]         addrIndex;
    logic [offsetMsb-offsetLsb:0] addrOffset;

    logic lineValid;
    logic lineDirty;
    logic tagMatch;
    logic access;

    assign addrTag    = addr[wordBits-1:tagLsb];
    assign addrIndex  = addr[indexMsb:indexLsb];
    assign addrOffset = addr[offsetMsb:offsetLsb];

    assign lineValid = validArr[addrIndex];
    assign lineDirty = dirtyArr[addrIndex];
    assign tagMatch  = tagArr[addrIndex] == addrTag;

    // Only a load or a store counts as a lookup
    assign access = en & (rd | wr);

    assign hit  = access & lineValid & tagMatch;
    assign miss = access & ~(lineValid & tagMatch);

    // Dirty victim has to go back to memory first
    assign evictNeeded = miss & lineValid & lineDirty;

    // Word out of the indexed line
    assign rdata = dataArr[addrIndex].words[addrOffset];

    // Victim line and its rebuilt block address
    assign blkOut     = dataArr[addrIndex];
    assign victimAddr = {tagArr[addrIndex], addrIndex, {indexLsb{1'b0}}};

    // Valid and dirty bits
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            validArr <= '0;
            dirtyArr <= '0;
        end else if (en) begin
            if (ld) begin
                // Fresh line from memory is clean
                validArr[addrIndex] <= 1'b1;
                dirtyArr[addrIndex] <= 1'b0;
            end else if (wr && hit) begin
                dirtyArr[addrIndex] <= 1'b1;
            end
        end
    end

    // Line data and tags
    always_ff @(posedge clk) begin
        if (en) begin
            if (ld) begin
                dataArr[addrIndex] <= blkIn;
                tagArr[addrIndex]  <= addrTag;
            end else if (wr && hit) begin
                // Store hit replaces one word
                dataArr[addrIndex].words[addrOffset] <= wdata;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/memoryStage.sv ====
`default_nettype none

module memoryStage (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire memPkg::memReq_t req,
    input  wire memPkg::memExc_t exc,
    input  wire logic            cacheHit,
    input  wire logic            cacheEvictNeeded,
    input  wire logic [31:0]     cacheRdata,
    input  wire memPkg::line_t   victimLine,
    input  wire logic [31:0]     victimAddr,
    output logic                 cacheEn,
    output logic                 cacheRd,
    output logic                 cacheWr,
    output logic                 cacheLd,
    output logic [31:0]          cacheAddr,
    output logic [31:0]          cacheWdata,
    output memPkg::line_t        fillLine,
    output memPkg::mcReq_t       mcReq,
    input  wire memPkg::mcResp_t mcResp,
    output logic [31:0]          memoryOut,
    output logic                 memDone,
    output logic                 stallDma
);

    import memPkg::*;

    // One FSM for loads and stores
    typedef enum logic [2:0] {
        Idle,
        Lookup,
        Evict,
        Fill,
        Settle
    } stageState_t;

    stageState_t currState;
    stageState_t nextState;

    logic reqValid;
    logic excAny;

    assign reqValid = req.read | req.write;
    assign excAny   = exc.accessEx | exc.readEx | exc.fftEx;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            currState <= Idle;
        end else begin
            currState <= nextState;
        end
    end

    always_comb begin
        nextState  = currState;
        cacheEn    = 1'b0;
        cacheRd    = 1'b0;
        cacheWr    = 1'b0;
        cacheLd    = 1'b0;
        cacheAddr  = req.addr;
        cacheWdata = '0;
        fillLine   = '0;
        mcReq      = '0;
        memoryOut  = '0;
        memDone    = 1'b0;
        stallDma   = 1'b0;

        case (currState)
            Idle: begin
                // Excepted requests never leave Idle
                if (reqValid && !excAny) begin
                    nextState = Lookup;
                    stallDma  = 1'b1;
                end
            end
            Lookup: begin
                cacheEn    = 1'b1;
                cacheRd    = req.read;
                cacheWr    = req.write;
                cacheWdata = req.wdata;
                if (cacheHit) begin
                    // Store hit is written at this edge
                    memDone   = 1'b1;
                    memoryOut = req.read ? cacheRdata : '0;
                    nextState = Idle;
                end else begin
                    stallDma  = 1'b1;
                    nextState = cacheEvictNeeded ? Evict : Fill;
                end
            end
            Evict: begin
                // Cache still indexed by the request for the victim
                cacheEn         = 1'b1;
                stallDma        = 1'b1;
                mcReq.evict     = 1'b1;
                mcReq.lineAddr  = victimAddr[wordBits-1:indexLsb];
                mcReq.evictLine = victimLine;
                if (mcResp.evictDone) begin
                    nextState = Fill;
                end
            end
            Fill: begin
                cacheEn        = 1'b1;
                stallDma       = 1'b1;
                mcReq.miss     = 1'b1;
                mcReq.lineAddr = req.addr[wordBits-1:indexLsb];
                fillLine       = mcResp.fillLine;
                // Line lands in the cache on the valid pulse
                cacheLd        = mcResp.dataValid;
                if (mcResp.dataValid) begin
                    nextState = Settle;
                end
            end
            Settle: begin
                // One quiet cycle before the retry lookup
                stallDma  = 1'b1;
                nextState = Lookup;
            end
            default: begin
                nextState = Idle;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== design/regionGuard.sv ====
`default_nettype none

module regionGuard (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire memPkg::cfgWrite_t cfg,
    input  wire memPkg::memReq_t   req,
    input  wire logic              fftCalculating,
    output memPkg::memExc_t        exc
);

    import memPkg::*;

    // Region nibble registers
    logic [3:0] dataRegion;
    logic [3:0] fftRegion;

    logic [3:0] nibble;
    logic       inData;
    logic       inFft;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            dataRegion <= dataRegionReset;
            fftRegion  <= fftRegionReset;
        end else if (cfg.en) begin
            if (cfg.sel) begin
                fftRegion <= cfg.value;
            end else begin
                dataRegion <= cfg.value;
            end
        end
    end

    // Top address nibble picks the region
    assign nibble = req.addr[wordBits-1:wordBits-4];
    assign inData = nibble == dataRegion;
    assign inFft  = nibble == fftRegion;

    // Outside both regions
    assign exc.readEx   = req.read & ~inData & ~inFft;
    assign exc.accessEx = req.write & ~inData & ~inFft;

    // FFT data is off limits while the accelerator runs
    assign exc.fftEx = (req.read | req.write) & inFft & fftCalculating;

endmodule

`default_nettype wire

// ==== design/blockMemory.sv ====
`default_nettype none

module blockMemory (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire memPkg::mcReq_t mcReq,
    output memPkg::mcResp_t     mcResp
);

    import memPkg::*;

    localparam int blkBits = $clog2(memBlocks);

    // Line storage
    line_t memArr [memBlocks];

    // Cycles since the current request level was first seen
    logic [latCountBits-1:0] latCount;

    // Low address bits only so memory aliases every 4 KB
    logic [blkBits-1:0] blkIdx;

    logic fillReady;
    logic evictReady;

    assign blkIdx = mcReq.lineAddr[blkBits-1:0];

    assign fillReady  = mcReq.miss && (latCount == latCountBits'(fillLatency));
    assign evictReady = mcReq.evict && (latCount == latCountBits'(evictLatency));

    assign mcResp.dataValid = fillReady;
    assign mcResp.evictDone = evictReady;
    assign mcResp.fillLine  = memArr[blkIdx];

    // Latency counter
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            latCount <= '0;
        end else if (fillReady || evictReady) begin
            // Pulse given so restart for the next request
            latCount <= '0;
        end else if (mcReq.miss || mcReq.evict) begin
            latCount <= latCount + 1'b1;
        end else begin
            latCount <= '0;
        end
    end

    // Storage starts at zero
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < memBlocks; i++) begin
                memArr[i] <= '0;
            end
        end else if (evictReady) begin
            // Written back on the edge of the done pulse
            memArr[blkIdx] <= mcReq.evictLine;
        end
    end

endmodule

`default_nettype wire

// ==== design/memSubsystem.sv ====
`default_nettype none

module memSubsystem (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire memPkg::memReq_t   req,
    input  wire logic              fftCalculating,
    input  wire memPkg::cfgWrite_t cfg,
    output logic [31:0]            memoryOut,
    output logic                   memDone,
    output logic                   stallDma,
    output logic                   cacheMiss,
    output logic                   cacheEvict,
    output memPkg::memExc_t        exc
);

    import memPkg::*;

    // Stage to cache
    logic                cacheEn;
    logic                cacheRd;
    logic                cacheWr;
    logic                cacheLd;
    logic [wordBits-1:0] cacheAddr;
    logic [wordBits-1:0] cacheWdata;
    line_t               fillLine;

    // Cache back to stage
    logic                cacheHit;
    logic                cacheEvictNeeded;
    logic [wordBits-1:0] cacheRdata;
    line_t               victimLine;
    logic [wordBits-1:0] victimAddr;

    // Block memory bus
    mcReq_t  mcReq;
    mcResp_t mcResp;

    // Memory controller levels seen at the top
    assign cacheMiss  = mcReq.miss;
    assign cacheEvict = mcReq.evict;

    regionGuard u_regionGuard (
        .clk           (clk),
        .rst           (rst),
        .cfg           (cfg),
        .req           (req),
        .fftCalculating(fftCalculating),
        .exc           (exc)
    );

    memoryStage u_memoryStage (
        .clk             (clk),
        .rst             (rst),
        .req             (req),
        .exc             (exc),
        .cacheHit        (cacheHit),
        .cacheEvictNeeded(cacheEvictNeeded),
        .cacheRdata      (cacheRdata),
        .victimLine      (victimLine),
        .victimAddr      (victimAddr),
        .cacheEn         (cacheEn),
        .cacheRd         (cacheRd),
        .cacheWr         (cacheWr),
        .cacheLd         (cacheLd),
        .cacheAddr       (cacheAddr),
        .cacheWdata      (cacheWdata),
        .fillLine        (fillLine),
        .mcReq           (mcReq),
        .mcResp          (mcResp),
        .memoryOut       (memoryOut),
        .memDone         (memDone),
        .stallDma        (stallDma)
    );

    // Miss flag is implied by hit and enable in the stage
    dataCache u_dataCache (
        .clk        (clk),
        .rst        (rst),
        .en         (cacheEn),
        .rd         (cacheRd),
        .wr         (cacheWr),
        .ld         (cacheLd),
        .addr       (cacheAddr),
        .wdata      (cacheWdata),
        .blkIn      (fillLine),
        .rdata      (cacheRdata),
        .hit        (cacheHit),
        .miss       (),
        .evictNeeded(cacheEvictNeeded),
        .blkOut     (victimLine),
        .victimAddr (victimAddr)
    );

    blockMemory u_blockMemory (
        .clk   (clk),
        .rst   (rst),
        .mcReq (mcReq),
        .mcResp(mcResp)
    );

endmodule

`default_nettype wire

// ==== verification/clockGen.sv ====
`default_nettype none

module clockGen (
    output logic clk,
    output logic rst
);

    // Period of 40 with reset held for two rising edges
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== verification/memSubsystem_props.sv ====
`default_nettype none

module memSubsystemProps (
    input wire logic            clk,
    input wire logic            rst,
    input wire memPkg::memReq_t req,
    input wire memPkg::mcReq_t  mcReq,
    input wire logic            memDone,
    input wire logic            stallDma
);

    // Completion only for a live request
    doneNeedsReq: assert property (@(posedge clk) disable iff (rst)
        memDone |-> (req.read || req.write))
        else $error("memDone high with no request present");

    // One memory controller level at a time
    missOrEvict: assert property (@(posedge clk) disable iff (rst)
        !(mcReq.miss && mcReq.evict))
        else $error("miss and evict raised together");

    // Pipeline released in the completion cycle
    doneReleasesStall: assert property (@(posedge clk) disable iff (rst)
        memDone |-> !stallDma)
        else $error("stallDma high while memDone is high");

endmodule

bind memoryStage memSubsystemProps u_memSubsystemProps (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .mcReq   (mcReq),
    .memDone (memDone),
    .stallDma(stallDma)
);

`default_nettype wire

// ==== verification/memSubsystemTb.sv ====
`default_nettype none

module memSubsystemTb;

    import memPkg::*;

    // Run size and limits sized for a dirty miss as the worst case
    localparam int randomCount    = 300;
    localparam int requestCount   = randomCount + 40;
    localparam int worstReqCycles = 4 + (evictLatency + 1) + (fillLatency + 1) + 2;
    localparam int reqTimeout     = worstReqCycles + 5;
    localparam int cycleLimit     = requestCount * worstReqCycles + 200;

    logic        clk;
    logic        rst;
    memReq_t     req;
    logic        fftCalculating;
    cfgWrite_t   cfg;
    logic [31:0] memoryOut;
    logic        memDone;
    logic        stallDma;
    logic        cacheMiss;
    logic        cacheEvict;
    memExc_t     exc;

    // Reference model as a word array over 4 KB plus region copies
    logic [31:0] refMem [1024];
    logic [3:0]  refDataRegion;
    logic [3:0]  refFftRegion;
    logic        refFftBusy;

    logic [31:0] rngState;
    logic [31:0] addr;
    logic [31:0] data;
    int          errorCount;
    int          checkCount;
    int          testCount;
    int          testStart;
    int          cycleCount = 0;
    int          lat;
    logic        sawMiss;
    logic        sawEvict;

    clockGen u_clockGen (
        .clk(clk),
        .rst(rst)
    );

    memSubsystem u_memSubsystem (
        .clk           (clk),
        .rst           (rst),
        .req           (req),
        .fftCalculating(fftCalculating),
        .cfg           (cfg),
        .memoryOut     (memoryOut),
        .memDone       (memDone),
        .stallDma      (stallDma),
        .cacheMiss     (cacheMiss),
        .cacheEvict    (cacheEvict),
        .exc           (exc)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Expected exception bits from the region copies
    function automatic memExc_t predictExc(input logic isWrite, input logic [31:0] a);
        memExc_t    e;
        logic       legal;
        legal      = (a[31:28] == refDataRegion) || (a[31:28] == refFftRegion);
        e.readEx   = !isWrite && !legal;
        e.accessEx = isWrite && !legal;
        e.fftEx    = (a[31:28] == refFftRegion) && refFftBusy;
        return e;
    endfunction

    task automatic checkEqual(input logic [31:0] actual, input logic [31:0] expected,
                              input string msg);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("ERROR at time %0t: %s, got %h, expected %h", $time, msg, actual, expected);
        end
    endtask

    // One load or store held until the cycle after memDone
    task automatic runAccess(input logic isWrite, input logic [31:0] a,
                             input logic [31:0] wdata, output int latency,
                             output logic missSeen, output logic evictSeen);
        memExc_t     expExc;
        memReq_t     newReq;
        logic        done;
        logic [31:0] rdata;
        expExc         = predictExc(isWrite, a);
        newReq.read    = !isWrite;
        newReq.write   = isWrite;
        newReq.addr    = a;
        newReq.wdata   = wdata;
        done           = 1'b0;
        rdata          = '0;
        latency        = 0;
        missSeen       = 1'b0;
        evictSeen      = 1'b0;
        @(posedge clk);
        req <= newReq;
        @(negedge clk);
        checkEqual({29'b0, exc}, {29'b0, expExc}, "exception bits");
        if (expExc != '0) begin
            // Excepted request is dropped after one cycle
            checkEqual(memDone, 1'b0, "memDone on excepted request");
            checkEqual(stallDma, 1'b0, "stallDma on excepted request");
            @(posedge clk);
            req <= '0;
            @(negedge clk);
            // A stage that left Idle would still be stalling here
            checkEqual(memDone, 1'b0, "memDone after excepted request");
            checkEqual(stallDma, 1'b0, "stallDma after excepted request");
            latency = -1;
        end else begin
            while (!done && latency <= reqTimeout) begin
                if (cacheMiss) missSeen = 1'b1;
                if (cacheEvict) evictSeen = 1'b1;
                if (memDone) begin
                    done  = 1'b1;
                    rdata = memoryOut;
                    checkEqual(stallDma, 1'b0, "stallDma in done cycle");
                end else begin
                    checkEqual(stallDma, 1'b1, "stallDma while busy");
                    latency++;
                    @(negedge clk);
                end
            end
            if (!done) begin
                errorCount++;
                $display("Request to address %h never finished within %0d cycles",
                         a, reqTimeout);
            end
            @(posedge clk);
            req <= '0;
            if (done && !isWrite) checkEqual(rdata, refMem[a[11:2]], "load data");
            if (done && isWrite) refMem[a[11:2]] = wdata;
        end
    endtask

    task automatic writeRegion(input logic sel, input logic [3:0] value);
        cfgWrite_t newCfg;
        newCfg.en    = 1'b1;
        newCfg.sel   = sel;
        newCfg.value = value;
        @(posedge clk);
        cfg <= newCfg;
        @(posedge clk);
        cfg <= '0;
        if (sel) refFftRegion = value;
        else refDataRegion = value;
    endtask

    task automatic setFftBusy(input logic value);
        @(posedge clk);
        fftCalculating <= value;
        refFftBusy = value;
    endtask

    task automatic reportTest(input string name);
        testCount++;
        if (errorCount == testStart) $display("Test %0d %s: passed", testCount, name);
        else $display("Test %0d %s: failed, %0d errors", testCount, name,
                      errorCount - testStart);
        testStart = errorCount;
    endtask

    // Whole-run limit
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout after %0d cycles, the run did not complete", cycleCount);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        req            = '0;
        fftCalculating = 1'b0;
        cfg            = '0;
        refDataRegion  = 4'h1;
        refFftRegion   = 4'h2;
        refFftBusy     = 1'b0;
        rngState       = 32'he47;
        errorCount     = 0;
        checkCount     = 0;
        testCount      = 0;
        testStart      = 0;
        for (int i = 0; i < 1024; i++) refMem[i] = '0;
        wait (rst == 1'b0);
        @(posedge clk);

        // Cold line reads zero after a clean fill
        runAccess(1'b0, 32'h1000_0F00, '0, lat, sawMiss, sawEvict);
        checkEqual(sawMiss, 1'b1, "cacheMiss on cold line");
        checkEqual(lat, fillLatency + 4, "clean miss latency");
        reportTest("cold load");

        // Few tags and lines so conflicts and write-backs are common
        for (int i = 0; i < randomCount; i++) begin
            rngState = xorshift(rngState);
            addr     = 32'h1000_0000 | {19'b0, rngState[2:0], 2'b0, rngState[4:3],
                                        rngState[8:5], 2'b00};
            data     = xorshift(rngState);
            runAccess(rngState[9], addr, data, lat, sawMiss, sawEvict);
            rngState = data;
        end
        reportTest("random traffic");

        // Dirty line pushed out by a conflicting tag, then refilled
        runAccess(1'b1, 32'h1000_0C80, 32'hA5C3_0F12, lat, sawMiss, sawEvict);
        runAccess(1'b0, 32'h1000_0880, '0, lat, sawMiss, sawEvict);
        checkEqual(sawEvict, 1'b1, "cacheEvict on dirty conflict");
        runAccess(1'b0, 32'h1000_0C80, '0, lat, sawMiss, sawEvict);
        checkEqual(sawMiss, 1'b1, "refill after write-back");
        reportTest("write-back");

        // Resident line answers in one cycle
        runAccess(1'b0, 32'h1000_0C80, '0, lat, sawMiss, sawEvict);
        checkEqual(lat, 1, "hit latency");
        checkEqual(sawMiss, 1'b0, "cacheMiss on hit");
        runAccess(1'b0, 32'h1000_0CBC, '0, lat, sawMiss, sawEvict);
        checkEqual(lat, 1, "hit latency same line");
        checkEqual(sawMiss, 1'b0, "cacheMiss on same line");
        reportTest("repeat hit");

        // Outside both regions and then the FFT region while busy and idle
        runAccess(1'b0, 32'h5000_0000, '0, lat, sawMiss, sawEvict);
        runAccess(1'b1, 32'h7000_0010, 32'h1234_5678, lat, sawMiss, sawEvict);
        setFftBusy(1'b1);
        runAccess(1'b0, 32'h2000_0100, '0, lat, sawMiss, sawEvict);
        runAccess(1'b1, 32'h2000_0104, 32'hDEAD_0001, lat, sawMiss, sawEvict);
        setFftBusy(1'b0);
        runAccess(1'b1, 32'h2000_0104, 32'hBEEF_0002, lat, sawMiss, sawEvict);
        runAccess(1'b0, 32'h2000_0104, '0, lat, sawMiss, sawEvict);
        reportTest("exceptions");

        // Data region moved from nibble 1 to nibble 3
        writeRegion(1'b0, 4'h3);
        runAccess(1'b0, 32'h1000_0C80, '0, lat, sawMiss, sawEvict);
        runAccess(1'b1, 32'h1000_0040, 32'h0BAD_F00D, lat, sawMiss, sawEvict);
        runAccess(1'b1, 32'h3000_0040, 32'h600D_CAFE, lat, sawMiss, sawEvict);
        runAccess(1'b0, 32'h3000_0040, '0, lat, sawMiss, sawEvict);
        writeRegion(1'b0, 4'h1);
        runAccess(1'b0, 32'h1000_0C80, '0, lat, sawMiss, sawEvict);
        reportTest("region move");

        $display("Tests run: %0d, checks: %0d, errors: %0d", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
design/memPkg.sv
design/dataCache.sv
design/memoryStage.sv
design/regionGuard.sv
design/blockMemory.sv
design/memSubsystem.sv
verification/clockGen.sv
verification/memSubsystem_props.sv
verification/memSubsystemTb.sv

// ==== Bender.yml ====
package:
  name: memSubsystem

sources:
  - files:
      - design/memPkg.sv
      - design/dataCache.sv
      - design/memoryStage.sv
      - design/regionGuard.sv
      - design/blockMemory.sv
      - design/memSubsystem.sv
  - target: test
    files:
      - verification/clockGen.sv
      - verification/memSubsystem_props.sv
      - verification/memSubsystemTb.sv
